// ==== build.f ====
common/vec_isa_pkg.sv
common/vec_uarch_pkg.sv
lane/vec_lane_vrf.sv
lane/vec_lane.sv
verilog/vec_dispatcher.sv
verilog/vec_sequencer.sv
verilog/vec_unit.sv
dv/vec_unit_sva.sv
dv/vec_unit_tb.sv

// ==== common/vec_isa_pkg.sv ====
// Vector unit ISA package with host opcodes and register index types
`default_nettype none

package vec_isa_pkg;

  // Host opcodes
  // Codes 10 to 15 are decoded as illegal
  typedef enum logic [3:0] {
    OP_SETVL  = 4'd0,
    OP_VID    = 4'd1,
    OP_SPLAT  = 4'd2,
    OP_ADD_VV = 4'd3,
    OP_SUB_VV = 4'd4,
    OP_AND_VV = 4'd5,
    OP_OR_VV  = 4'd6,
    OP_XOR_VV = 4'd7,
    OP_ADD_VX = 4'd8,
    OP_READ   = 4'd9
  } vec_op_e;

  // Architectural vector registers
  localparam int unsigned NumVRegs = 8;

  typedef logic [$clog2(NumVRegs)-1:0] vreg_idx_t;

endpackage : vec_isa_pkg

`default_nettype wire

// ==== common/vec_uarch_pkg.sv ====
// Vector unit microarchitecture package with lane operations and pipeline depth
`default_nettype none

package vec_uarch_pkg;

  // Operation carried by a row command to the lanes
  typedef enum logic [2:0] {
    LANE_IDX    = 3'd0,
    LANE_SCALAR = 3'd1,
    LANE_ADD    = 3'd2,
    LANE_SUB    = 3'd3,
    LANE_AND    = 3'd4,
    LANE_OR     = 3'd5,
    LANE_XOR    = 3'd6,
    LANE_READ   = 3'd7
  } lane_op_e;

  // Operand stage plus execute stage
  localparam int unsigned LaneDepth = 2;

endpackage : vec_uarch_pkg

`default_nettype wire

// ==== dv/vec_unit_sva.sv ====
// Protocol assertions bound to the vector unit top level
`timescale 1ns/10ps
`default_nettype none

module vec_unit_sva import vec_isa_pkg::*; import vec_uarch_pkg::*; #(
  parameter int unsigned NrLanes   = 4,
  parameter int unsigned ElemWidth = 32
) (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 req_ready_i,
  input logic                 resp_valid_i,
  input logic                 illegal_i,
  // Dispatch register
  input logic                 dec_valid_i,
  input logic                 dec_ready_i,
  input lane_op_e             dec_op_i,
  input logic                 dec_is_setvl_i,
  input vreg_idx_t            dec_vd_i,
  input vreg_idx_t            dec_vs1_i,
  input vreg_idx_t            dec_vs2_i,
  input logic                 dec_use_scalar_i,
  input logic [ElemWidth-1:0] dec_scalar_i,
  // Lane command
  input logic [NrLanes-1:0]   lane_valid_i,
  input lane_op_e             lane_op_i
);

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown({req_ready_i, resp_valid_i, illegal_i}))
  else $error("Handshake or response outputs unknown");

  // A stalled entry must not change
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dec_valid_i && !dec_ready_i |=> dec_valid_i &&
      $stable({dec_op_i, dec_is_setvl_i, dec_vd_i, dec_vs1_i, dec_vs2_i,
               dec_use_scalar_i, dec_scalar_i}))
  else $error("Dispatch register changed while stalled");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lane_op_i == LANE_READ |-> $onehot0(lane_valid_i))
  else $error("READ issued to more than one lane");

endmodule : vec_unit_sva

bind vec_unit vec_unit_sva #(
  .NrLanes   (NrLanes  ),
  .ElemWidth (ElemWidth)
) u_sva (
  .clk_i            (clk_i         ),
  .rst_n_i          (rst_n_i       ),
  .req_ready_i      (req_ready_o   ),
  .resp_valid_i     (resp_valid_o  ),
  .illegal_i        (illegal_o     ),
  .dec_valid_i      (dec_valid     ),
  .dec_ready_i      (dec_ready     ),
  .dec_op_i         (dec_op        ),
  .dec_is_setvl_i   (dec_is_setvl  ),
  .dec_vd_i         (dec_vd        ),
  .dec_vs1_i        (dec_vs1       ),
  .dec_vs2_i        (dec_vs2       ),
  .dec_use_scalar_i (dec_use_scalar),
  .dec_scalar_i     (dec_scalar    ),
  .lane_valid_i     (lane_valid    ),
  .lane_op_i        (lane_op       )
);

`default_nettype wire

// ==== dv/vec_unit_tb.sv ====
// Testbench for the vector unit with random stimulus checked against a reference model
`timescale 1ns/10ps
`default_nettype none

module vec_unit_tb import vec_isa_pkg::*; ();

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned VLenPerLane  = 4;
  localparam int unsigned ElemWidth    = 32;
  localparam int unsigned VLMAX        = NrLanes * VLenPerLane;
  localparam int unsigned NumZeroReads = 4;
  localparam int unsigned NumSetvl     = 8;
  localparam int unsigned NumRounds    = 6;
  localparam int unsigned OpsPerRound  = 4;
  localparam int unsigned NumIllegal   = 4;
  localparam int unsigned NumReqs      = NumZeroReads + NumSetvl + 5 + 2 * VLMAX +
                                         NumRounds * (1 + 2 * OpsPerRound) +
                                         1 + 2 * NumIllegal;

  logic                 clk;
  logic                 rst_n;
  logic                 req_valid;
  logic                 req_ready;
  vec_op_e              req_op;
  vreg_idx_t            req_vd;
  vreg_idx_t            req_vs1;
  vreg_idx_t            req_vs2;
  logic [ElemWidth-1:0] req_scalar;
  logic                 resp_valid;
  logic [ElemWidth-1:0] resp_data;
  logic                 illegal;

  // Reference model state
  logic [63:0]          lcg_state;
  logic [31:0]          vreg_model [NumVRegs][VLMAX];
  int unsigned          vl_model;
  logic [31:0]          exp_q [$];
  int unsigned          illegal_exp;
  int unsigned          illegal_seen;

  vec_unit #(
    .NrLanes     (NrLanes    ),
    .VLenPerLane (VLenPerLane),
    .ElemWidth   (ElemWidth  )
  ) u_dut (
    .clk_i        (clk       ),
    .rst_n_i      (rst_n     ),
    .req_valid_i  (req_valid ),
    .req_ready_o  (req_ready ),
    .req_op_i     (req_op    ),
    .req_vd_i     (req_vd    ),
    .req_vs1_i    (req_vs1   ),
    .req_vs2_i    (req_vs2   ),
    .req_scalar_i (req_scalar),
    .resp_valid_o (resp_valid),
    .resp_data_o  (resp_data ),
    .illegal_o    (illegal   )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // 64-bit LCG, upper half returned
  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state[63:32];
  endfunction

  function automatic vreg_idx_t rand_reg();
    logic [31:0] r;
    r = rand_next();
    return r[2:0];
  endfunction

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR time=%0t %s got=0x%08h expected=0x%08h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Element result, with vs1 as a and vs2 as b
  function automatic logic [31:0] elem_result(input logic [3:0] op, input int unsigned e,
                                              input logic [31:0] a, input logic [31:0] b,
                                              input logic [31:0] s);
    case (vec_op_e'(op))
      OP_VID:    return 32'(e);
      OP_SPLAT:  return s;
      OP_ADD_VV: return b + a;
      OP_SUB_VV: return b - a;
      OP_AND_VV: return b & a;
      OP_OR_VV:  return b | a;
      OP_XOR_VV: return b ^ a;
      OP_ADD_VX: return b + s;
      default:   return b;
    endcase
  endfunction

  task automatic apply_model(input logic [3:0] op, input vreg_idx_t vd, input vreg_idx_t vs1,
                             input vreg_idx_t vs2, input logic [31:0] s);
    int unsigned idx;
    case (vec_op_e'(op))
      OP_SETVL: begin
        vl_model = (s > 32'(VLMAX)) ? VLMAX : s;
        exp_q.push_back(32'(vl_model));
      end
      OP_READ: begin
        idx = s % VLMAX;
        exp_q.push_back(vreg_model[vs2][idx]);
      end
      OP_VID, OP_SPLAT, OP_ADD_VV, OP_SUB_VV, OP_AND_VV, OP_OR_VV, OP_XOR_VV, OP_ADD_VX: begin
        // Tail elements at or above vl keep their value
        for (int unsigned e = 0; e < vl_model; e++) begin
          vreg_model[vd][e] = elem_result(op, e, vreg_model[vs1][e], vreg_model[vs2][e], s);
        end
      end
      default: illegal_exp++;
    endcase
  endtask

  // Starts and ends on a falling edge
  task automatic drive_request(input logic [3:0] op, input vreg_idx_t vd, input vreg_idx_t vs1,
                               input vreg_idx_t vs2, input logic [31:0] s, input bit gap_en);
    int unsigned gap;
    gap = gap_en ? rand_next() % 4 : 0;
    if (gap != 0) begin
      req_valid = 1'b0;
      repeat (gap) @(negedge clk);
    end
    req_op     = vec_op_e'(op);
    req_vd     = vd;
    req_vs1    = vs1;
    req_vs2    = vs2;
    req_scalar = s;
    req_valid  = 1'b1;
    // Ready depends on registers only, so it is settled here
    while (!req_ready) @(negedge clk);
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic issue(input logic [3:0] op, input vreg_idx_t vd, input vreg_idx_t vs1,
                       input vreg_idx_t vs2, input logic [31:0] s, input bit gap_en);
    apply_model(op, vd, vs1, vs2, s);
    drive_request(op, vd, vs1, vs2, s, gap_en);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    logic [31:0] s;
    logic [3:0]  op;
    vreg_idx_t   vd;
    lcg_state    = 64'd83;
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_op       = OP_SETVL;
    req_vd       = '0;
    req_vs1      = '0;
    req_vs2      = '0;
    req_scalar   = '0;
    vl_model     = 0;
    illegal_exp  = 0;
    illegal_seen = 0;
    for (int r = 0; r < NumVRegs; r++) begin
      for (int e = 0; e < VLMAX; e++) begin
        vreg_model[r][e] = '0;
      end
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("req_ready_o", 32'(req_ready), 32'd1);
    check_value("resp_valid_o", 32'(resp_valid), 32'd0);
    check_value("illegal_o", 32'(illegal), 32'd0);

    // Registers read as zero out of reset
    repeat (NumZeroReads) issue(OP_READ, 3'd0, 3'd0, rand_reg(), rand_next(), 1'b1);

    // SETVL clamping, odd steps use full range values
    for (int i = 0; i < NumSetvl; i++) begin
      s = rand_next();
      if (i == 0) begin
        s = 0;
      end else if (i % 2 == 0) begin
        s = s % 24;
      end
      issue(OP_SETVL, 3'd0, 3'd0, 3'd0, s, 1'b1);
    end

    // VID and SPLAT over a short vl, tails come from the full-length SPLAT
    issue(OP_SETVL, 3'd0, 3'd0, 3'd0, 32'(VLMAX), 1'b1);
    issue(OP_SPLAT, 3'd1, 3'd0, 3'd0, rand_next(), 1'b1);
    issue(OP_SETVL, 3'd0, 3'd0, 3'd0, 32'd1 + rand_next() % 15, 1'b1);
    issue(OP_VID, 3'd1, 3'd0, 3'd0, 32'd0, 1'b0);
    issue(OP_SPLAT, 3'd2, 3'd0, 3'd0, rand_next(), 1'b0);
    for (int e = 0; e < VLMAX; e++) begin
      issue(OP_READ, 3'd0, 3'd0, 3'd1, 32'(e), 1'b1);
    end
    for (int e = 0; e < VLMAX; e++) begin
      issue(OP_READ, 3'd0, 3'd0, 3'd2, 32'(e), 1'b1);
    end

    // Back to back arithmetic on the low four registers
    for (int r = 0; r < NumRounds; r++) begin
      issue(OP_SETVL, 3'd0, 3'd0, 3'd0, rand_next() % 18, 1'b1);
      for (int i = 0; i < OpsPerRound; i++) begin
        op = 4'(OP_ADD_VV) + 4'(rand_next() % 6);
        issue(op, rand_reg() & 3'd3, rand_reg() & 3'd3, rand_reg() & 3'd3, rand_next(), 1'b0);
      end
      for (int i = 0; i < OpsPerRound; i++) begin
        issue(OP_READ, 3'd0, 3'd0, rand_reg() & 3'd3, rand_next(), 1'b1);
      end
    end

    // Illegal codes 10 to 15 over a full vl, each followed by a READ of its vd
    issue(OP_SETVL, 3'd0, 3'd0, 3'd0, 32'(VLMAX), 1'b1);
    for (int i = 0; i < NumIllegal; i++) begin
      op = 4'd10 + 4'(rand_next() % 6);
      vd = rand_reg() & 3'd3;
      issue(op, vd, rand_reg() & 3'd3, rand_reg() & 3'd3, rand_next(), 1'b1);
      issue(OP_READ, 3'd0, 3'd0, vd, rand_next(), 1'b0);
    end

    while (exp_q.size() != 0) @(negedge clk);
    check_value("illegal_o pulse count", 32'(illegal_seen), 32'(illegal_exp));
    $display("TEST OK");
    $finish;
  end

  ////////////////////
  // Response monitor
  ////////////////////

  initial begin
    forever begin
      @(negedge clk);
      if (illegal) begin
        illegal_seen++;
      end
      if (resp_valid) begin
        if (exp_q.size() == 0) begin
          $display("Response at time %0t with no request waiting for one", $time);
          abort_run();
        end else begin
          check_value("resp_data_o", resp_data, exp_q.pop_front());
        end
      end
    end
  end

  // Generous per-request budget plus reset
  initial begin
    repeat (NumReqs * 30 + 16) @(posedge clk);
    $display("Watchdog expired with %0d responses still outstanding", exp_q.size());
    abort_run();
  end

endmodule : vec_unit_tb

`default_nettype wire

// ==== lane/vec_lane.sv ====
// Vector lane with an operand stage and an execute stage around its register file
`timescale 1ns/10ps
`default_nettype none

module vec_lane import vec_isa_pkg::*; import vec_uarch_pkg::*; #(
  parameter  int unsigned NrLanes     = 4,
  parameter  int unsigned VLenPerLane = 4,
  parameter  int unsigned ElemWidth   = 32,
  parameter  int unsigned LaneId      = 0,
  localparam int unsigned RowW        = (VLenPerLane > 1) ? $clog2(VLenPerLane) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Row command from the sequencer
  input  logic                 cmd_valid_i,
  input  lane_op_e             cmd_op_i,
  input  logic [RowW-1:0]      cmd_row_i,
  input  vreg_idx_t            cmd_vd_i,
  input  vreg_idx_t            cmd_vs1_i,
  input  vreg_idx_t            cmd_vs2_i,
  input  logic                 cmd_use_scalar_i,
  input  logic [ElemWidth-1:0] cmd_scalar_i,
  // Read data back to the sequencer
  output logic                 rd_valid_o,
  output logic [ElemWidth-1:0] rd_data_o
);

  // One valid bit per pipeline stage
  logic [LaneDepth-1:0] stage_vld_q;
  lane_op_e             op_q;
  logic [RowW-1:0]      row_q;
  vreg_idx_t            vd_q;
  logic [ElemWidth-1:0] opa_q;
  logic [ElemWidth-1:0] opb_q;
  logic [ElemWidth-1:0] rdata_a;
  logic [ElemWidth-1:0] rdata_b;
  logic [ElemWidth-1:0] result;
  logic                 we;

  vec_lane_vrf #(
    .VLenPerLane (VLenPerLane),
    .ElemWidth   (ElemWidth  )
  ) i_vrf (
    .clk_i     (clk_i                 ),
    .rst_n_i   (rst_n_i               ),
    .raddr_a_i ({cmd_vs1_i, cmd_row_i}),
    .raddr_b_i ({cmd_vs2_i, cmd_row_i}),
    .we_i      (we                    ),
    .waddr_i   ({vd_q, row_q}         ),
    .wdata_i   (result                ),
    .rdata_a_o (rdata_a               ),
    .rdata_b_o (rdata_b               )
  );

  ////////////////////
  // Operand stage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      op_q  <= cmd_op_i;
      row_q <= cmd_row_i;
      vd_q  <= cmd_vd_i;
      // SPLAT and ADD_VX take the scalar in place of vs1
      opa_q <= (cmd_use_scalar_i || cmd_op_i == LANE_SCALAR) ? cmd_scalar_i : rdata_a;
      opb_q <= rdata_b;
    end
  end

  ////////////////////
  // Execute stage
  ////////////////////

  // Subtract is vs2 minus vs1
  always_comb begin
    case (op_q)
      LANE_IDX:    result = ElemWidth'(row_q * NrLanes + LaneId);
      LANE_SCALAR: result = opa_q;
      LANE_ADD:    result = opb_q + opa_q;
      LANE_SUB:    result = opb_q - opa_q;
      LANE_AND:    result = opb_q & opa_q;
      LANE_OR:     result = opb_q | opa_q;
      LANE_XOR:    result = opb_q ^ opa_q;
      default:     result = opb_q;
    endcase
  end

  assign we = stage_vld_q[0] & (op_q != LANE_READ);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stage_vld_q <= '0;
    end else begin
      stage_vld_q[0]           <= cmd_valid_i;
      // Only reads go on to produce an output
      stage_vld_q[LaneDepth-1] <= stage_vld_q[0] & (op_q == LANE_READ);
    end
  end

  always_ff @(posedge clk_i) begin
    if (stage_vld_q[0] && op_q == LANE_READ) begin
      rd_data_o <= opb_q;
    end
  end

  assign rd_valid_o = stage_vld_q[LaneDepth-1];

endmodule : vec_lane

`default_nettype wire

// ==== lane/vec_lane_vrf.sv ====
// Lane vector register file with two combinational reads and one synchronous write
`timescale 1ns/10ps
`default_nettype none

module vec_lane_vrf import vec_isa_pkg::*; #(
  parameter  int unsigned VLenPerLane = 4,
  parameter  int unsigned ElemWidth   = 32,
  localparam int unsigned RowW        = (VLenPerLane > 1) ? $clog2(VLenPerLane) : 1,
  localparam int unsigned AddrW       = $clog2(NumVRegs) + RowW
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Address is the register index above the row
  input  logic [AddrW-1:0]     raddr_a_i,
  input  logic [AddrW-1:0]     raddr_b_i,
  input  logic                 we_i,
  input  logic [AddrW-1:0]     waddr_i,
  input  logic [ElemWidth-1:0] wdata_i,
  output logic [ElemWidth-1:0] rdata_a_o,
  output logic [ElemWidth-1:0] rdata_b_o
);

  localparam int unsigned Depth = 2 ** AddrW;

  logic [ElemWidth-1:0] mem_q [Depth];

  // Every register reads as zero after reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < Depth; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = mem_q[raddr_a_i];
  assign rdata_b_o = mem_q[raddr_b_i];

endmodule : vec_lane_vrf

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the vector unit testbench with Verilator
# The exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module vec_unit_tb -Mdir obj_dir -f build.f \
  && ./obj_dir/Vvec_unit_tb \
  || { echo "Simulation did not pass"; exit 1; }

// ==== verilog/vec_dispatcher.sv ====
// Vector dispatcher that decodes host requests into a one-entry issue register
`timescale 1ns/10ps
`default_nettype none

module vec_dispatcher import vec_isa_pkg::*; import vec_uarch_pkg::*; #(
  parameter int unsigned NrLanes     = 4,
  parameter int unsigned VLenPerLane = 4,
  parameter int unsigned ElemWidth   = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Host request
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  vec_op_e              req_op_i,
  input  vreg_idx_t            req_vd_i,
  input  vreg_idx_t            req_vs1_i,
  input  vreg_idx_t            req_vs2_i,
  input  logic [ElemWidth-1:0] req_scalar_i,
  output logic                 illegal_o,
  // Decoded instruction to the sequencer
  output logic                 dec_valid_o,
  input  logic                 dec_ready_i,
  output lane_op_e             dec_op_o,
  output logic                 dec_is_setvl_o,
  output vreg_idx_t            dec_vd_o,
  output vreg_idx_t            dec_vs1_o,
  output vreg_idx_t            dec_vs2_o,
  output logic                 dec_use_scalar_o,
  output logic [ElemWidth-1:0] dec_scalar_o
);

  localparam int unsigned VLMAX = NrLanes * VLenPerLane;

  lane_op_e             op_d;
  logic                 legal_d;
  logic                 use_scalar_d;
  logic [ElemWidth-1:0] scalar_d;
  logic                 accept;

  ////////////////////
  // Decode
  ////////////////////

  // READ names its register in vs2 and its element in the scalar
  always_comb begin
    op_d         = LANE_ADD;
    legal_d      = 1'b1;
    use_scalar_d = 1'b0;
    scalar_d     = req_scalar_i;
    case (req_op_i)
      OP_SETVL: begin
        if (req_scalar_i > ElemWidth'(VLMAX)) begin
          scalar_d = ElemWidth'(VLMAX);
        end
      end
      OP_VID:    op_d = LANE_IDX;
      OP_SPLAT:  op_d = LANE_SCALAR;
      OP_ADD_VV: op_d = LANE_ADD;
      OP_SUB_VV: op_d = LANE_SUB;
      OP_AND_VV: op_d = LANE_AND;
      OP_OR_VV:  op_d = LANE_OR;
      OP_XOR_VV: op_d = LANE_XOR;
      OP_ADD_VX: begin
        op_d         = LANE_ADD;
        use_scalar_d = 1'b1;
      end
      OP_READ:   op_d = LANE_READ;
      default:   legal_d = 1'b0;
    endcase
  end

  ////////////////////
  // Issue register
  ////////////////////

  // Free slot, or the held entry leaves this cycle
  assign req_ready_o = ~dec_valid_o | dec_ready_i;
  assign accept      = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_valid_o <= 1'b0;
      illegal_o   <= 1'b0;
    end else begin
      // Illegal requests are consumed here and never reach the sequencer
      illegal_o <= accept & ~legal_d;
      if (accept) begin
        dec_valid_o <= legal_d;
      end else if (dec_ready_i) begin
        dec_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && legal_d) begin
      dec_op_o         <= op_d;
      dec_is_setvl_o   <= (req_op_i == OP_SETVL);
      dec_vd_o         <= req_vd_i;
      dec_vs1_o        <= req_vs1_i;
      dec_vs2_o        <= req_vs2_i;
      dec_use_scalar_o <= use_scalar_d;
      dec_scalar_o     <= scalar_d;
    end
  end

endmodule : vec_dispatcher

`default_nettype wire

// ==== verilog/vec_sequencer.sv ====
// Vector sequencer that owns vl, broadcasts row commands and orders responses
`timescale 1ns/10ps
`default_nettype none

module vec_sequencer import vec_isa_pkg::*; import vec_uarch_pkg::*; #(
  parameter  int unsigned NrLanes     = 4,
  parameter  int unsigned VLenPerLane = 4,
  parameter  int unsigned ElemWidth   = 32,
  localparam int unsigned RowW        = (VLenPerLane > 1) ? $clog2(VLenPerLane) : 1
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Decoded instruction
  input  logic                              dec_valid_i,
  output logic                              dec_ready_o,
  input  lane_op_e                          dec_op_i,
  input  logic                              dec_is_setvl_i,
  input  vreg_idx_t                         dec_vd_i,
  input  vreg_idx_t                         dec_vs1_i,
  input  vreg_idx_t                         dec_vs2_i,
  input  logic                              dec_use_scalar_i,
  input  logic [ElemWidth-1:0]              dec_scalar_i,
  // Row commands to the lanes
  output logic [NrLanes-1:0]                lane_valid_o,
  output lane_op_e                          lane_op_o,
  output logic [RowW-1:0]                   lane_row_o,
  output vreg_idx_t                         lane_vd_o,
  output vreg_idx_t                         lane_vs1_o,
  output vreg_idx_t                         lane_vs2_o,
  output logic                              lane_use_scalar_o,
  output logic [ElemWidth-1:0]              lane_scalar_o,
  input  logic [NrLanes-1:0]                lane_rd_valid_i,
  input  logic [NrLanes-1:0][ElemWidth-1:0] lane_rd_data_i,
  // Host responses
  output logic                              resp_valid_o,
  output logic [ElemWidth-1:0]              resp_data_o
);

  localparam int unsigned VLMAX = NrLanes * VLenPerLane;
  localparam int unsigned VlW   = $clog2(VLMAX + 1);
  localparam int unsigned LaneW = (NrLanes > 1) ? $clog2(NrLanes) : 1;
  localparam int unsigned CntW  = $clog2(LaneDepth + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_DRAIN,
    S_RUN,
    S_BUBBLE,
    S_WAIT
  } seq_state_e;

  seq_state_e           state_q;
  logic [VlW-1:0]       vl_q;
  logic [RowW-1:0]      row_last_q;
  logic [LaneW-1:0]     rd_lane_q;
  logic [CntW-1:0]      drain_q;
  logic                 setvl_resp_q;
  logic                 accept;
  logic                 rd_hit;
  logic [ElemWidth-1:0] elem_idx;
  logic [RowW-1:0]      last_row;
  logic [RowW-1:0]      read_row;
  logic [LaneW-1:0]     read_lane;
  logic [NrLanes-1:0]   row_mask;

  assign dec_ready_o = (state_q == S_IDLE);
  assign accept      = dec_valid_i & dec_ready_o;

  // Element e sits in lane e mod NrLanes, row e / NrLanes
  assign elem_idx  = ElemWidth'(dec_scalar_i % VLMAX);
  assign read_row  = RowW'(elem_idx / NrLanes);
  assign read_lane = LaneW'(elem_idx % NrLanes);
  // Only meaningful for a nonzero vl
  assign last_row  = RowW'((vl_q - 1'b1) / NrLanes);

  // Tail elements at or above vl are left untouched
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      row_mask[l] = (lane_row_o * NrLanes + l) < vl_q;
    end
  end

  always_comb begin
    lane_valid_o = '0;
    if (state_q == S_RUN) begin
      lane_valid_o = (lane_op_o == LANE_READ) ? NrLanes'(1) << rd_lane_q : row_mask;
    end
  end

  ////////////////////
  // Responses
  ////////////////////

  assign rd_hit       = (state_q == S_WAIT) & lane_rd_valid_i[rd_lane_q];
  assign resp_valid_o = setvl_resp_q | rd_hit;
  assign resp_data_o  = setvl_resp_q ? ElemWidth'(vl_q) : lane_rd_data_i[rd_lane_q];

  ////////////////////
  // Control FSM
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= S_IDLE;
      vl_q         <= '0;
      lane_row_o   <= '0;
      drain_q      <= '0;
      setvl_resp_q <= 1'b0;
    end else begin
      setvl_resp_q <= accept & dec_is_setvl_i;
      case (state_q)
        S_IDLE: begin
          if (accept && dec_is_setvl_i) begin
            vl_q <= VlW'(dec_scalar_i);
          end else if (accept && dec_op_i == LANE_READ) begin
            // Let earlier writes leave the lane pipelines
            lane_row_o <= read_row;
            drain_q    <= CntW'(LaneDepth);
            state_q    <= S_DRAIN;
          end else if (accept) begin
            lane_row_o <= '0;
            state_q    <= (vl_q == '0) ? S_BUBBLE : S_RUN;
          end
        end
        S_DRAIN: begin
          drain_q <= drain_q - 1'b1;
          if (drain_q == CntW'(1)) begin
            state_q <= S_RUN;
          end
        end
        S_RUN: begin
          lane_row_o <= lane_row_o + 1'b1;
          if (lane_row_o == row_last_q) begin
            state_q <= (lane_op_o == LANE_READ) ? S_WAIT : S_BUBBLE;
          end
        end
        S_WAIT: begin
          if (rd_hit) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Command fields held for the whole instruction
  always_ff @(posedge clk_i) begin
    if (accept && !dec_is_setvl_i) begin
      lane_op_o         <= dec_op_i;
      lane_vd_o         <= dec_vd_i;
      lane_vs1_o        <= dec_vs1_i;
      lane_vs2_o        <= dec_vs2_i;
      lane_use_scalar_o <= dec_use_scalar_i;
      lane_scalar_o     <= dec_scalar_i;
      row_last_q        <= (dec_op_i == LANE_READ) ? read_row : last_row;
      rd_lane_q         <= read_lane;
    end
  end

endmodule : vec_sequencer

`default_nettype wire

// ==== verilog/vec_unit.sv ====
// Vector unit top level joining the dispatcher, the sequencer and the lanes
`timescale 1ns/10ps
`default_nettype none

module vec_unit import vec_isa_pkg::*; import vec_uarch_pkg::*; #(
  parameter  int unsigned NrLanes     = 4,
  parameter  int unsigned VLenPerLane = 4,
  parameter  int unsigned ElemWidth   = 32,
  localparam int unsigned RowW        = (VLenPerLane > 1) ? $clog2(VLenPerLane) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Host request
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  vec_op_e              req_op_i,
  input  vreg_idx_t            req_vd_i,
  input  vreg_idx_t            req_vs1_i,
  input  vreg_idx_t            req_vs2_i,
  input  logic [ElemWidth-1:0] req_scalar_i,
  // Host response
  output logic                 resp_valid_o,
  output logic [ElemWidth-1:0] resp_data_o,
  output logic                 illegal_o
);

  // Dispatcher to sequencer
  logic                 dec_valid;
  logic                 dec_ready;
  lane_op_e             dec_op;
  logic                 dec_is_setvl;
  vreg_idx_t            dec_vd;
  vreg_idx_t            dec_vs1;
  vreg_idx_t            dec_vs2;
  logic                 dec_use_scalar;
  logic [ElemWidth-1:0] dec_scalar;

  // Sequencer to lanes
  logic [NrLanes-1:0]                lane_valid;
  lane_op_e                          lane_op;
  logic [RowW-1:0]                   lane_row;
  vreg_idx_t                         lane_vd;
  vreg_idx_t                         lane_vs1;
  vreg_idx_t                         lane_vs2;
  logic                              lane_use_scalar;
  logic [ElemWidth-1:0]              lane_scalar;
  logic [NrLanes-1:0]                lane_rd_valid;
  logic [NrLanes-1:0][ElemWidth-1:0] lane_rd_data;

  vec_dispatcher #(
    .NrLanes     (NrLanes    ),
    .VLenPerLane (VLenPerLane),
    .ElemWidth   (ElemWidth  )
  ) i_dispatcher (
    .clk_i            (clk_i         ),
    .rst_n_i          (rst_n_i       ),
    .req_valid_i      (req_valid_i   ),
    .req_ready_o      (req_ready_o   ),
    .req_op_i         (req_op_i      ),
    .req_vd_i         (req_vd_i      ),
    .req_vs1_i        (req_vs1_i     ),
    .req_vs2_i        (req_vs2_i     ),
    .req_scalar_i     (req_scalar_i  ),
    .illegal_o        (illegal_o     ),
    .dec_valid_o      (dec_valid     ),
    .dec_ready_i      (dec_ready     ),
    .dec_op_o         (dec_op        ),
    .dec_is_setvl_o   (dec_is_setvl  ),
    .dec_vd_o         (dec_vd        ),
    .dec_vs1_o        (dec_vs1       ),
    .dec_vs2_o        (dec_vs2       ),
    .dec_use_scalar_o (dec_use_scalar),
    .dec_scalar_o     (dec_scalar    )
  );

  vec_sequencer #(
    .NrLanes     (NrLanes    ),
    .VLenPerLane (VLenPerLane),
    .ElemWidth   (ElemWidth  )
  ) i_sequencer (
    .clk_i             (clk_i          ),
    .rst_n_i           (rst_n_i        ),
    .dec_valid_i       (dec_valid      ),
    .dec_ready_o       (dec_ready      ),
    .dec_op_i          (dec_op         ),
    .dec_is_setvl_i    (dec_is_setvl   ),
    .dec_vd_i          (dec_vd         ),
    .dec_vs1_i         (dec_vs1        ),
    .dec_vs2_i         (dec_vs2        ),
    .dec_use_scalar_i  (dec_use_scalar ),
    .dec_scalar_i      (dec_scalar     ),
    .lane_valid_o      (lane_valid     ),
    .lane_op_o         (lane_op        ),
    .lane_row_o        (lane_row       ),
    .lane_vd_o         (lane_vd        ),
    .lane_vs1_o        (lane_vs1       ),
    .lane_vs2_o        (lane_vs2       ),
    .lane_use_scalar_o (lane_use_scalar),
    .lane_scalar_o     (lane_scalar    ),
    .lane_rd_valid_i   (lane_rd_valid  ),
    .lane_rd_data_i    (lane_rd_data   ),
    .resp_valid_o      (resp_valid_o   ),
    .resp_data_o       (resp_data_o    )
  );

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .NrLanes     (NrLanes    ),
      .VLenPerLane (VLenPerLane),
      .ElemWidth   (ElemWidth  ),
      .LaneId      (l          )
    ) i_lane (
      .clk_i            (clk_i           ),
      .rst_n_i          (rst_n_i         ),
      .cmd_valid_i      (lane_valid[l]   ),
      .cmd_op_i         (lane_op         ),
      .cmd_row_i        (lane_row        ),
      .cmd_vd_i         (lane_vd         ),
      .cmd_vs1_i        (lane_vs1        ),
      .cmd_vs2_i        (lane_vs2        ),
      .cmd_use_scalar_i (lane_use_scalar ),
      .cmd_scalar_i     (lane_scalar     ),
      .rd_valid_o       (lane_rd_valid[l]),
      .rd_data_o        (lane_rd_data[l] )
    );
  end : gen_lanes

endmodule : vec_unit

`default_nettype wire
